//--- source/fetch_settings.svh
/*
 * Fetch front end build settings
 * Word width, prefetch FIFO depth and bus request limit
 */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Address and instruction word width
`define FETCH_XLEN 32

// Prefetch FIFO entries, power of two
`define FETCH_FIFO_DEPTH 4

// Granted requests still waiting for rvalid
`define FETCH_MAX_OUTSTANDING 2

`endif

//--- source/fetch_pkg.sv
/*
 * Fetch front end package
 * Shared vector types, fetch FSM encoding and the JAL opcode
 */
`include "fetch_settings.svh"

package fetch_pkg;

  // Byte address and raw instruction word
  typedef logic [`FETCH_XLEN-1:0] addr_t;
  typedef logic [`FETCH_XLEN-1:0] instr_t;

  // FIFO occupancy, counts 0 to depth inclusive
  localparam int unsigned LEVEL_W = $clog2(`FETCH_FIFO_DEPTH + 1);
  typedef logic [LEVEL_W-1:0] fill_level_t;

  // Fetch FSM
  typedef enum logic {
    FETCH_IDLE,
    FETCH_RUN
  } fetch_state_e;

  // RV32I major opcode of JAL
  localparam logic [6:0] OPCODE_JAL = 7'b1101111;

endpackage

//--- source/fetch_buf_if.sv
/*
 * Fetch to prefetch FIFO link
 * Write strobe with word, PC and error flag, flush, and fill level back
 */
`timescale 1ns/1ps

interface fetch_buf_if;

  // Write side, one entry per push strobe
  logic                   push;
  fetch_pkg::addr_t       push_pc;
  fetch_pkg::instr_t      push_instr;
  logic                   push_err;

  // Empties the buffer, beats a push in the same cycle
  logic                   flush;

  // Current occupancy
  fetch_pkg::fill_level_t level;

  modport producer (
    output push, push_pc, push_instr, push_err, flush,
    input  level
  );

  modport buffer (
    input  push, push_pc, push_instr, push_err, flush,
    output level
  );

endinterface

//--- source/issue_buf_if.sv
/*
 * Prefetch FIFO to decode/issue link
 * Head entry with valid, popped by the issue stage
 */
`timescale 1ns/1ps

interface issue_buf_if;

  // Head of the FIFO
  logic              valid;
  fetch_pkg::addr_t  pc;
  fetch_pkg::instr_t instr;
  logic              err;

  // Only while valid
  logic              pop;

  modport buffer (
    output valid, pc, instr, err,
    input  pop
  );

  modport consumer (
    input  valid, pc, instr, err,
    output pop
  );

endinterface

//--- source/instr_fetch.sv
/*
 * Instruction fetch unit
 * Raises word requests on the req/gnt/rvalid instruction bus, keeps
 * count of outstanding and discarded responses, and pushes each
 * returned word with its own PC into the prefetch FIFO. A redirect
 * flushes the FIFO and moves fetching to the jump target.
 */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module instr_fetch (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              fetch_enable_i,
  input  fetch_pkg::addr_t  boot_addr_i,
  output logic              instr_req_o,
  output fetch_pkg::addr_t  instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  fetch_pkg::instr_t instr_rdata_i,
  input  logic              instr_err_i,
  input  logic              redirect_i,
  input  fetch_pkg::addr_t  redirect_pc_i,
  fetch_buf_if.producer     buf_o
);

  localparam int unsigned MAX_OUT = `FETCH_MAX_OUTSTANDING;
  localparam int unsigned CNT_W   = $clog2(MAX_OUT + 1);
  localparam int unsigned QPTR_W  = (MAX_OUT > 1) ? $clog2(MAX_OUT) : 1;

  fetch_pkg::fetch_state_e state_q, state_d;
  fetch_pkg::addr_t        pc_q;
  fetch_pkg::addr_t        redir_pc_q;
  logic                    redir_pend_q;
  logic [CNT_W-1:0]        out_cnt_q, out_cnt_d;
  logic [CNT_W-1:0]        disc_cnt_q, disc_cnt_d;
  fetch_pkg::addr_t        pc_queue [MAX_OUT];
  logic [QPTR_W-1:0]       q_wr_q, q_rd_q;
  logic                    room, grant, req_waiting, resp_drop;

  // Ring step for the PC queue pointers
  function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] ptr);
    return (ptr == QPTR_W'(MAX_OUT - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////
  // Bus request side
  ////////////////////

  // FIFO slots reserved for every response in flight
  assign room = (int'(buf_o.level) + int'(out_cnt_q) < `FETCH_FIFO_DEPTH) &&
                (int'(out_cnt_q) < MAX_OUT);

  assign instr_req_o  = (state_q == fetch_pkg::FETCH_RUN) && room;
  assign instr_addr_o = pc_q;
  assign grant        = instr_req_o && instr_gnt_i;
  // Raised but not granted, address must hold
  assign req_waiting  = instr_req_o && !instr_gnt_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::FETCH_IDLE: if (fetch_enable_i) state_d = fetch_pkg::FETCH_RUN;
      fetch_pkg::FETCH_RUN:  if (!fetch_enable_i && !req_waiting) state_d = fetch_pkg::FETCH_IDLE;
      default:               state_d = fetch_pkg::FETCH_IDLE;
    endcase
  end

  ////////////////////
  // Response side
  ////////////////////

  // Oldest responses belong to the old path while the discard count is set
  assign resp_drop = instr_rvalid_i && (disc_cnt_q != '0);

  always_comb begin
    out_cnt_d = out_cnt_q;
    if (grant && !instr_rvalid_i) out_cnt_d = out_cnt_q + 1'b1;
    else if (!grant && instr_rvalid_i) out_cnt_d = out_cnt_q - 1'b1;
    disc_cnt_d = disc_cnt_q;
    if (resp_drop) disc_cnt_d = disc_cnt_d - 1'b1;
    // Request held across an earlier redirect, its word is stale
    if (grant && redir_pend_q) disc_cnt_d = disc_cnt_d + 1'b1;
    // Everything still in flight after this cycle is wrong path
    if (redirect_i) disc_cnt_d = out_cnt_d;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= fetch_pkg::FETCH_IDLE;
      pc_q         <= boot_addr_i;
      redir_pend_q <= 1'b0;
      out_cnt_q    <= '0;
      disc_cnt_q   <= '0;
      q_wr_q       <= '0;
      q_rd_q       <= '0;
    end else begin
      state_q    <= state_d;
      out_cnt_q  <= out_cnt_d;
      disc_cnt_q <= disc_cnt_d;
      if (grant) q_wr_q <= next_ptr(q_wr_q);
      if (instr_rvalid_i) q_rd_q <= next_ptr(q_rd_q);
      // Target parked until the held request is granted
      if (redirect_i && req_waiting) redir_pend_q <= 1'b1;
      else if (grant) redir_pend_q <= 1'b0;
      if (redirect_i && !req_waiting) pc_q <= redirect_pc_i;
      else if (grant) pc_q <= redir_pend_q ? redir_pc_q : pc_q + fetch_pkg::addr_t'(4);
    end
  end

  // PCs granted and not yet answered, oldest at the read pointer
  always_ff @(posedge clk_i) begin
    if (grant) pc_queue[q_wr_q] <= instr_addr_o;
    if (redirect_i && req_waiting) redir_pc_q <= redirect_pc_i;
  end

  assign buf_o.push       = instr_rvalid_i && !resp_drop;
  assign buf_o.push_pc    = pc_queue[q_rd_q];
  assign buf_o.push_instr = instr_rdata_i;
  assign buf_o.push_err   = instr_err_i;
  assign buf_o.flush      = redirect_i;

endmodule

//--- source/prefetch_fifo.sv
/*
 * Prefetch FIFO
 * Circular buffer of fetched words with PC and error flag.
 * Flush drops all entries in one cycle.
 */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module prefetch_fifo (
  input  logic        clk_i,
  input  logic        reset_i,
  fetch_buf_if.buffer buf_i,
  issue_buf_if.buffer issue_o
);

  localparam int unsigned DEPTH = `FETCH_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Entry storage
  fetch_pkg::addr_t       mem_pc    [DEPTH];
  fetch_pkg::instr_t      mem_instr [DEPTH];
  logic                   mem_err   [DEPTH];

  logic [PTR_W-1:0]       wr_ptr_q, rd_ptr_q;
  fetch_pkg::fill_level_t level_q;
  logic                   wr_en, rd_en;

  assign wr_en = buf_i.push;
  assign rd_en = issue_o.pop;

  ////////////////////
  // Pointers and level
  ////////////////////

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i || buf_i.flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  // Write port, ignored while flushing
  always_ff @(posedge clk_i) begin
    if (wr_en && !buf_i.flush) begin
      mem_pc[wr_ptr_q]    <= buf_i.push_pc;
      mem_instr[wr_ptr_q] <= buf_i.push_instr;
      mem_err[wr_ptr_q]   <= buf_i.push_err;
    end
  end

  // Head entry, visible the cycle after its push
  assign issue_o.valid = (level_q != '0);
  assign issue_o.pc    = mem_pc[rd_ptr_q];
  assign issue_o.instr = mem_instr[rd_ptr_q];
  assign issue_o.err   = mem_err[rd_ptr_q];

  assign buf_i.level   = level_q;

endmodule

//--- source/decode_issue.sv
/*
 * Decode and issue stage
 * Holds one instruction in an output register under valid/ready,
 * spots JAL at the FIFO head and redirects fetch to its target
 */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module decode_issue (
  input  logic               clk_i,
  input  logic               reset_i,
  issue_buf_if.consumer      issue_i,
  output logic               issue_valid_o,
  input  logic               issue_ready_i,
  output fetch_pkg::addr_t   issue_pc_o,
  output fetch_pkg::instr_t  issue_instr_o,
  output logic               issue_err_o,
  output logic               redirect_o,
  output fetch_pkg::addr_t   redirect_pc_o
);

  logic              out_valid_q;
  fetch_pkg::addr_t  out_pc_q;
  fetch_pkg::instr_t out_instr_q;
  logic              out_err_q;
  logic              pop;
  logic              take_jal;
  fetch_pkg::addr_t  jal_imm;

  // Load when empty or when the held word leaves this cycle
  assign pop         = issue_i.valid && (!out_valid_q || issue_ready_i);
  assign issue_i.pop = pop;

  ////////////////////
  // JAL decode
  ////////////////////

  // Faulted words are never taken as jumps
  assign take_jal = (issue_i.instr[6:0] == fetch_pkg::OPCODE_JAL) && !issue_i.err;

  // J-type immediate, imm[20|10:1|11|19:12], sign extended
  assign jal_imm = {{(`FETCH_XLEN - 20){issue_i.instr[31]}},
                    issue_i.instr[19:12],
                    issue_i.instr[20],
                    issue_i.instr[30:21],
                    1'b0};

  assign redirect_o    = pop && take_jal;
  assign redirect_pc_o = issue_i.pc + jal_imm;

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_q <= 1'b0;
    end else if (pop) begin
      out_valid_q <= 1'b1;
    end else if (issue_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  // Payload, holds while stalled
  always_ff @(posedge clk_i) begin
    if (pop) begin
      out_pc_q    <= issue_i.pc;
      out_instr_q <= issue_i.instr;
      out_err_q   <= issue_i.err;
    end
  end

  assign issue_valid_o = out_valid_q;
  assign issue_pc_o    = out_pc_q;
  assign issue_instr_o = out_instr_q;
  assign issue_err_o   = out_err_q;

endmodule

//--- source/fetch_core.sv
/*
 * Fetch front end top level
 * Fetch unit, prefetch FIFO and decode/issue stage on plain ports
 */
`timescale 1ns/1ps

module fetch_core (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              fetch_enable_i,
  input  fetch_pkg::addr_t  boot_addr_i,
  // Instruction bus
  output logic              instr_req_o,
  output fetch_pkg::addr_t  instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  fetch_pkg::instr_t instr_rdata_i,
  input  logic              instr_err_i,
  // Issue handshake
  output logic              issue_valid_o,
  input  logic              issue_ready_i,
  output fetch_pkg::addr_t  issue_pc_o,
  output fetch_pkg::instr_t issue_instr_o,
  output logic              issue_err_o
);

  // Jump redirect, decode back to fetch
  logic             redirect;
  fetch_pkg::addr_t redirect_pc;

  fetch_buf_if fetch_buf ();
  issue_buf_if issue_buf ();

  instr_fetch fetch_unit (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_err_i    ( instr_err_i    ),
    .redirect_i     ( redirect       ),
    .redirect_pc_i  ( redirect_pc    ),
    .buf_o          ( fetch_buf      )
  );

  prefetch_fifo prefetch_buffer (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .buf_i   ( fetch_buf ),
    .issue_o ( issue_buf )
  );

  decode_issue issue_stage (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .issue_i       ( issue_buf     ),
    .issue_valid_o ( issue_valid_o ),
    .issue_ready_i ( issue_ready_i ),
    .issue_pc_o    ( issue_pc_o    ),
    .issue_instr_o ( issue_instr_o ),
    .issue_err_o   ( issue_err_o   ),
    .redirect_o    ( redirect      ),
    .redirect_pc_o ( redirect_pc   )
  );

endmodule

//--- sim/fetch_core_assert.sv
/*
 * Protocol assertions for the fetch front end
 * Quiet reset, bus request hold until grant, issue hold under stall
 */
`timescale 1ns/1ps

module fetch_core_assert (
  input logic              clk_i,
  input logic              reset_i,
  input logic              instr_req_o,
  input fetch_pkg::addr_t  instr_addr_o,
  input logic              instr_gnt_i,
  input logic              issue_valid_o,
  input logic              issue_ready_i,
  input fetch_pkg::addr_t  issue_pc_o,
  input fetch_pkg::instr_t issue_instr_o,
  input logic              issue_err_o
);

  // Number of failed assertions so far
  int unsigned fail_count = 0;

  // Nothing requested or issued right after a reset edge
  reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> !instr_req_o && !issue_valid_o)
    else begin
      fail_count++;
      $error("bus request or issue valid while reset is active");
    end

  // Request and address stay put until granted
  req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else begin
      fail_count++;
      $error("instr_req_o or instr_addr_o changed before grant");
    end

  // Stalled issue keeps its payload
  issue_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    issue_valid_o && !issue_ready_i |=> issue_valid_o && $stable(issue_pc_o)
      && $stable(issue_instr_o) && $stable(issue_err_o))
    else begin
      fail_count++;
      $error("issue outputs changed while valid and not ready");
    end

endmodule

//--- sim/tb_fetch_core.sv
/*
 * Testbench for the fetch front end
 * Random grants, response delays and issue back-pressure over a
 * JAL-rich memory image. Every issue transfer is checked against
 * a PC reference walk.
 */
`timescale 1ns/1ps

module tb_fetch_core;

  localparam int unsigned      RESET_CYCLES     = 8;
  localparam int unsigned      IDLE_CYCLES      = 20;
  localparam int unsigned      NUM_ISSUES       = 600;
  // Rough cost of one issue with jump refills included
  localparam int unsigned      CYCLES_PER_ISSUE = 6;
  localparam int unsigned      TIMEOUT_CYCLES   =
    4 * (RESET_CYCLES + IDLE_CYCLES + NUM_ISSUES * CYCLES_PER_ISSUE);
  localparam fetch_pkg::addr_t BOOT_ADDR        = 32'h1000_0000;
  // Bus error window over the upper half of one odd block
  localparam fetch_pkg::addr_t ERR_LO           = 32'h1000_0170;
  localparam fetch_pkg::addr_t ERR_HI           = 32'h1000_017f;

  logic              clk_i = 1'b0;
  logic              reset_i;
  logic              fetch_enable_i;
  fetch_pkg::addr_t  boot_addr_i;
  logic              instr_req_o;
  fetch_pkg::addr_t  instr_addr_o;
  logic              instr_gnt_i;
  logic              instr_rvalid_i;
  fetch_pkg::instr_t instr_rdata_i;
  logic              instr_err_i;
  logic              issue_valid_o;
  logic              issue_ready_i;
  fetch_pkg::addr_t  issue_pc_o;
  fetch_pkg::instr_t issue_instr_o;
  logic              issue_err_o;

  logic [31:0]       lfsr_state = 32'h7509294a;
  int                cycle_count = 0;
  int                checked_count = 0;
  // Granted addresses in order, with the cycle their answer is due
  fetch_pkg::addr_t  pend_addr[$];
  int                pend_due[$];
  // Issue outputs captured mid-cycle
  logic              xfer_due;
  fetch_pkg::addr_t  seen_pc;
  fetch_pkg::instr_t seen_instr;
  logic              seen_err;
  fetch_pkg::addr_t  exp_pc;

  fetch_core dut (.*);

  bind fetch_core fetch_core_assert protocol_checks (.*);

  always #20 clk_i = ~clk_i;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic logic in_err_range(input fetch_pkg::addr_t a);
    return (a >= ERR_LO) && (a <= ERR_HI);
  endfunction

  // Even blocks leap three blocks ahead, odd blocks step back into the previous one
  function automatic int jal_offset(input fetch_pkg::addr_t a);
    return a[5] ? -52 : 68;
  endfunction

  // Memory image, last word of every 8-word block is a JAL
  function automatic fetch_pkg::instr_t mem_word(input fetch_pkg::addr_t a);
    logic [31:0] off;
    off = 32'(jal_offset(a));
    if (a[4:2] == 3'd7) begin
      return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    end
    // ADDI-shaped filler with all address bits folded in
    return {a[31:7] ^ {a[6:2], 20'h3c5a1}, 7'b0010011};
  endfunction

  // Reference walk, faulted JAL slots fall through
  function automatic fetch_pkg::addr_t next_pc(input fetch_pkg::addr_t pc);
    if ((pc[4:2] == 3'd7) && !in_err_range(pc)) begin
      return pc + fetch_pkg::addr_t'(jal_offset(pc));
    end
    return pc + 32'd4;
  endfunction

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_pc(input string name, input fetch_pkg::addr_t got,
                          input fetch_pkg::addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic compare_word(input string name, input fetch_pkg::instr_t got,
                              input fetch_pkg::instr_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    reset_i        = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    issue_ready_i  = 1'b0;
    xfer_due       = 1'b0;
    exp_pc         = BOOT_ADDR;
    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;
    // Front end stays quiet until enabled
    repeat (IDLE_CYCLES) begin
      @(negedge clk_i);
      expect_bit("instr_req_o", instr_req_o, 1'b0);
      expect_bit("issue_valid_o", issue_valid_o, 1'b0);
    end
    fetch_enable_i = 1'b1;
  end

  // Memory model and issue back-pressure
  always @(negedge clk_i) begin
    logic [31:0] bits;
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d issues checked, front end hung",
               cycle_count, checked_count, NUM_ISSUES);
      stop_with_failure();
    end
    // DUT takes the grant at the next rising edge
    take_bits(1, bits);
    instr_gnt_i = (instr_req_o === 1'b1) && bits[0];
    if (instr_gnt_i) begin
      take_bits(2, bits);
      pend_addr.push_back(instr_addr_o);
      pend_due.push_back(cycle_count + 1 + int'(bits[1:0] % 3));
    end
    // Oldest grant answered once its delay runs out
    if ((pend_addr.size() > 0) && (pend_due[0] <= cycle_count)) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = mem_word(pend_addr[0]);
      instr_err_i    = in_err_range(pend_addr[0]);
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end else begin
      instr_rvalid_i = 1'b0;
      instr_rdata_i  = '0;
      instr_err_i    = 1'b0;
    end
    // Ready three times in four
    take_bits(2, bits);
    issue_ready_i = (bits[1:0] != 2'b00);
    xfer_due      = issue_valid_o && issue_ready_i;
    seen_pc       = issue_pc_o;
    seen_instr    = issue_instr_o;
    seen_err      = issue_err_o;
  end

  ////////////////////
  // Checking
  ////////////////////

  always @(posedge clk_i) begin
    if (xfer_due) begin
      check_pc("issue_pc_o", seen_pc, exp_pc);
      compare_word("issue_instr_o", seen_instr, mem_word(exp_pc));
      expect_bit("issue_err_o", seen_err, in_err_range(exp_pc));
      exp_pc = next_pc(exp_pc);
      checked_count++;
      if (checked_count == NUM_ISSUES) begin
        // Bound protocol assertions must also be clean
        if (dut.protocol_checks.fail_count == 0) begin
          $display("Done: no errors");
          $finish;
        end else begin
          stop_with_failure();
        end
      end
    end
  end

endmodule

//--- project.f
+incdir+source
source/fetch_pkg.sv
source/fetch_buf_if.sv
source/issue_buf_if.sv
source/instr_fetch.sv
source/prefetch_fifo.sv
source/decode_issue.sv
source/fetch_core.sv
sim/fetch_core_assert.sv
sim/tb_fetch_core.sv
